// ==== hw/isaPkg.sv ====
// ========================================
// Instruction set definitions: opcodes, the
// instruction word with its field views, and
// the operating-mode encoding
// ========================================

package isaPkg;

	// Width of the immediate carried by an immediate-prefix instruction
	localparam int IMM_PREFIX_BITS = 25;

	// MOV sub-operations below this value take a seven bit source register
	localparam logic [2:0] MOV_SUB_HIGH_LIMIT = 3'd4;
	// MOV sub-operation that moves between operating-mode banks
	localparam logic [2:0] MOV_SUB_MOVEMD = 3'd1;

	typedef enum logic [6:0] {
		OP_ADD   = 7'd4,
		OP_SUB   = 7'd5,
		OP_CSR   = 7'd7,
		OP_AND   = 7'd8,
		OP_OR    = 7'd9,
		OP_XOR   = 7'd10,
		OP_CMP   = 7'd11,
		OP_MUL   = 7'd12,
		OP_DIV   = 7'd13,
		OP_SHIFT = 7'd14,
		OP_FLT   = 7'd16,
		OP_MOV   = 7'd18,
		OP_B     = 7'd32,
		OP_BCC   = 7'd40,
		OP_LOAD  = 7'd64,
		OP_STORE = 7'd80,
		OP_PUSH  = 7'd88,
		OP_POP   = 7'd89,
		OP_IMM   = 7'd120,
		OP_NOP   = 7'd127
	} opcodeE;

	// Modes are ordered by privilege, user is the lowest
	typedef enum logic [1:0] {
		MODE_USER    = 2'd0,
		MODE_SUPER   = 2'd1,
		MODE_HYPER   = 2'd2,
		MODE_MACHINE = 2'd3
	} operatingModeE;

	// ========================================
	// Instruction word views
	// ========================================

	// Register format used by ALU, float, CSR, load and store instructions
	typedef struct packed {
		logic [9:0] upper;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [4:0] rd;
		opcodeE     opcode;
	} regFmtT;

	// Branch format, bit 31 selects an absolute target on OP_B
	typedef struct packed {
		logic        b31;
		logic [5:0]  pad30;
		logic [2:0]  bRs;
		logic [14:0] pad21;
		opcodeE      opcode;
	} brFmtT;

	// MOV format with the sub-operation, the target mode and the upper source bits
	typedef struct packed {
		logic [2:0]  pad31;
		logic [2:0]  movSub;
		logic        pad25;
		logic [1:0]  modeField;
		logic [1:0]  pad22;
		logic [1:0]  highRs1;
		logic [11:0] pad18;
		opcodeE      opcode;
	} movFmtT;

	// Immediate prefix, everything above the opcode is payload
	typedef struct packed {
		logic [IMM_PREFIX_BITS-1:0] imm;
		opcodeE                     opcode;
	} immFmtT;

	typedef union packed {
		regFmtT regFmt;
		brFmtT  brFmt;
		movFmtT movFmt;
		immFmtT immFmt;
	} instructionT;

endpackage

// ==== hw/cpuTypesPkg.sv ====
// ========================================
// Processor internal types: register numbers,
// the fetched instruction and the decoded
// operand bundle
// ========================================

package cpuTypesPkg;

	// Architectural register number
	// 0..31 general, 32..63 float, 64..71 branch, 120..127 banked stack pointers
	typedef logic [6:0] aregNoT;

	// General register 31 is the stack pointer and gets banked by mode
	localparam aregNoT AREG_SP = 7'd31;
	// First of the mode-banked stack-pointer slots
	localparam aregNoT AREG_SLOT_BASE = 7'd120;

	// What the front end hands over for every instruction
	typedef struct packed {
		isaPkg::instructionT   instr;
		isaPkg::operatingModeE mode;
	} fetchedInstrT;

	// Operands after selection and bank mapping
	typedef struct packed {
		aregNoT      rs1;
		aregNoT      rs2;
		aregNoT      rd;
		logic        rs1Zero;
		logic        rs2Zero;
		logic        hasImma;
		logic        excRegPriv;
		logic [31:0] imm;
	} decodedOperandsT;

endpackage

// ==== hw/regMapper.sv ====
// ========================================
// Mode bank mapping of one register number
// with the privilege check on banked slots
// ========================================

`timescale 1ns/100ps

module regMapper
(
	input  isaPkg::operatingModeE mode,
	input  cpuTypesPkg::aregNoT   areg,
	output cpuTypesPkg::aregNoT   mapped,
	output logic                  exc
);

	// Slot index inside the banked stack-pointer group
	logic [2:0] slot;

	assign slot = areg[2:0];

	always_comb
	begin
		mapped = areg;
		exc = 1'b0;
		if (areg == cpuTypesPkg::AREG_SP)
		begin
			// The stack pointer is replaced by the copy that belongs to the mode
			mapped = cpuTypesPkg::AREG_SLOT_BASE + cpuTypesPkg::aregNoT'(mode);
		end
		else if (areg[6:3] == cpuTypesPkg::AREG_SLOT_BASE[6:3])
		begin
			// A banked slot named directly may only be one at or below the mode.
			// Slots 124 and up are reserved and always trap
			exc = (slot > {1'b0, mode}) || slot[2];
		end
	end

endmodule

// ==== hw/decodeRs1.sv ====
// ========================================
// Source 1 selection per opcode, MOVEMD mode
// override and bank mapping
// ========================================

`timescale 1ns/100ps

module decodeRs1
(
	input  isaPkg::operatingModeE mode,
	input  isaPkg::instructionT   instr,
	input  logic                  hasImma,
	output cpuTypesPkg::aregNoT   rs1,
	output logic                  rs1Zero,
	output logic                  exc
);

	cpuTypesPkg::aregNoT   selRs1;
	isaPkg::operatingModeE mapMode;
	logic                  isMovemd;

	// Register number before banking
	always_comb
	begin
		if (hasImma)
			// A pending prefix stands in for source 1
			selRs1 = '0;
		else
			case (instr.regFmt.opcode)
			isaPkg::OP_MOV:
				if (instr.movFmt.movSub < isaPkg::MOV_SUB_HIGH_LIMIT)
					selRs1 = {instr.movFmt.highRs1, instr.regFmt.rs1};
				else
					selRs1 = {2'b00, instr.regFmt.rs1};
			isaPkg::OP_FLT:
				selRs1 = {2'b01, instr.regFmt.rs1};
			isaPkg::OP_ADD, isaPkg::OP_SUB, isaPkg::OP_AND, isaPkg::OP_OR,
			isaPkg::OP_XOR, isaPkg::OP_CMP, isaPkg::OP_MUL, isaPkg::OP_DIV,
			isaPkg::OP_SHIFT, isaPkg::OP_CSR, isaPkg::OP_LOAD, isaPkg::OP_STORE:
				selRs1 = {2'b00, instr.regFmt.rs1};
			isaPkg::OP_B:
				// Absolute branches and branch register 0 read no register
				selRs1 = (instr.brFmt.b31 || instr.brFmt.bRs == 3'd0) ?
					'0 : {4'b1000, instr.brFmt.bRs};
			isaPkg::OP_BCC:
				// Branch registers 0 and 7 mean no register on conditional branches
				selRs1 = (instr.brFmt.bRs == 3'd0 || instr.brFmt.bRs == 3'd7) ?
					'0 : {4'b1000, instr.brFmt.bRs};
			default:
				// PUSH, POP and the rest do not use source 1
				selRs1 = '0;
			endcase
	end

	// MOVEMD reaches into the bank named by the instruction
	assign isMovemd = (instr.regFmt.opcode == isaPkg::OP_MOV) &&
		(instr.movFmt.movSub == isaPkg::MOV_SUB_MOVEMD);
	assign mapMode = isMovemd ? isaPkg::operatingModeE'(instr.movFmt.modeField) : mode;

	assign rs1Zero = (selRs1 == '0);

	regMapper mapRs1
	(
		.mode   (mapMode),
		.areg   (selRs1),
		.mapped (rs1),
		.exc    (exc)
	);

endmodule

// ==== hw/decodeRs2Rd.sv ====
// ========================================
// Source 2 and destination selection per
// opcode, each mapped through the banks
// ========================================

`timescale 1ns/100ps

module decodeRs2Rd
(
	input  isaPkg::operatingModeE mode,
	input  isaPkg::instructionT   instr,
	output cpuTypesPkg::aregNoT   rs2,
	output logic                  rs2Zero,
	output cpuTypesPkg::aregNoT   rd,
	output logic                  exc
);

	cpuTypesPkg::aregNoT selRs2;
	cpuTypesPkg::aregNoT selRd;
	logic                excRs2;
	logic                excRd;

	always_comb
	begin
		selRs2 = '0;
		selRd = '0;
		case (instr.regFmt.opcode)
		isaPkg::OP_ADD, isaPkg::OP_SUB, isaPkg::OP_AND, isaPkg::OP_OR,
		isaPkg::OP_XOR, isaPkg::OP_CMP, isaPkg::OP_MUL, isaPkg::OP_DIV,
		isaPkg::OP_SHIFT:
		begin
			selRs2 = {2'b00, instr.regFmt.rs2};
			selRd = {2'b00, instr.regFmt.rd};
		end
		isaPkg::OP_FLT:
		begin
			// Float operands live in the second group of 32
			selRs2 = {2'b01, instr.regFmt.rs2};
			selRd = {2'b01, instr.regFmt.rd};
		end
		isaPkg::OP_CSR, isaPkg::OP_MOV, isaPkg::OP_LOAD:
			selRd = {2'b00, instr.regFmt.rd};
		isaPkg::OP_STORE:
			// Stores read the data register and write nothing
			selRs2 = {2'b00, instr.regFmt.rs2};
		isaPkg::OP_PUSH, isaPkg::OP_POP:
			// The stack pointer is updated implicitly
			selRd = cpuTypesPkg::AREG_SP;
		default:
		begin
			selRs2 = '0;
			selRd = '0;
		end
		endcase
	end

	assign rs2Zero = (selRs2 == '0);

	regMapper mapRs2
	(
		.mode   (mode),
		.areg   (selRs2),
		.mapped (rs2),
		.exc    (excRs2)
	);

	regMapper mapRd
	(
		.mode   (mode),
		.areg   (selRd),
		.mapped (rd),
		.exc    (excRd)
	);

	assign exc = excRs2 | excRd;

endmodule

// ==== hw/immPrefixTracker.sv ====
// ========================================
// Pending immediate prefix for the next
// instruction through the slice
// ========================================

`timescale 1ns/100ps

module immPrefixTracker
(
	input  logic                clk,
	input  logic                rstN,
	input  logic                advance,
	input  isaPkg::instructionT instr,
	output logic                hasImma,
	output logic [31:0]         imm
);

	logic                               prefixValid;
	logic [isaPkg::IMM_PREFIX_BITS-1:0] pendingImm;
	logic                               isPrefix;

	assign isPrefix = (instr.immFmt.opcode == isaPkg::OP_IMM);

	// Every instruction that moves on either opens a prefix or consumes it
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			prefixValid <= 1'b0;
		else if (advance)
			prefixValid <= isPrefix;
	end

	always_ff @(posedge clk)
	begin
		if (advance && isPrefix)
			pendingImm <= instr.immFmt.imm;
	end

	assign hasImma = prefixValid;
	assign imm = prefixValid ? {{(32 - isaPkg::IMM_PREFIX_BITS){1'b0}}, pendingImm} : '0;

	// Nothing may survive a reset into the first instruction
	assert property (@(posedge clk) !$past(rstN) |-> !hasImma);

endmodule

// ==== hw/handshakeStage.sv ====
// ========================================
// One-entry four-phase req/ack register
// stage for any payload type
// ========================================

`timescale 1ns/100ps

module handshakeStage #(
	parameter type payloadT = logic [31:0]
)
(
	input  logic    clk,
	input  logic    rstN,
	input  logic    inReq,
	output logic    inAck,
	input  payloadT inData,
	output logic    outReq,
	input  logic    outAck,
	output payloadT outData
);

	// Output side runs request, then waits for the sink to release its ack
	typedef enum logic [1:0] {OUT_IDLE, OUT_REQ, OUT_RELEASE} outPhaseE;

	outPhaseE outPhase;
	logic     full;
	logic     capture;
	payloadT  held;

	// A new request is taken only when the entry is free and the last ack is down
	assign capture = inReq && !inAck && !full;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			full <= 1'b0;
			inAck <= 1'b0;
			outPhase <= OUT_IDLE;
		end
		else
		begin
			// Input side
			if (capture)
			begin
				inAck <= 1'b1;
				full <= 1'b1;
			end
			else if (inAck && !inReq)
				inAck <= 1'b0;

			// Output side, the entry is freed only after the ack goes low again
			case (outPhase)
			OUT_IDLE:
				if (full && !outAck)
					outPhase <= OUT_REQ;
			OUT_REQ:
				if (outAck)
					outPhase <= OUT_RELEASE;
			OUT_RELEASE:
				if (!outAck)
				begin
					outPhase <= OUT_IDLE;
					full <= 1'b0;
				end
			default:
				outPhase <= OUT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
			held <= inData;
	end

	assign outReq = (outPhase == OUT_REQ);
	assign outData = held;

	// The sink may sample the payload at any point of the request phase
	assert property (@(posedge clk) disable iff (!rstN)
		outReq && $past(outReq) |-> $stable(outData));

	// A request is only withdrawn once the sink has acknowledged it
	assert property (@(posedge clk) disable iff (!rstN)
		$fell(outReq) |-> $past(outAck));

endmodule

// ==== hw/operandDecodeUnit.sv ====
// ========================================
// Operand decode slice: input stage, prefix
// tracker, decoders and output stage
// ========================================

`timescale 1ns/100ps

module operandDecodeUnit
(
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         inReq,
	output logic                         inAck,
	input  cpuTypesPkg::fetchedInstrT    inData,
	output logic                         outReq,
	input  logic                         outAck,
	output cpuTypesPkg::decodedOperandsT outData
);

	// Internal channel between the two stages
	logic                         midReq;
	logic                         midAck;
	cpuTypesPkg::fetchedInstrT    midInstr;
	cpuTypesPkg::decodedOperandsT decoded;
	logic                         advance;
	logic                         hasImma;
	logic [31:0]                  imm;
	logic                         excRs1;
	logic                         excRs2Rd;

	handshakeStage #(.payloadT(cpuTypesPkg::fetchedInstrT)) inStage
	(
		.clk     (clk),
		.rstN    (rstN),
		.inReq   (inReq),
		.inAck   (inAck),
		.inData  (inData),
		.outReq  (midReq),
		.outAck  (midAck),
		.outData (midInstr)
	);

	// Req and ack both high happens for exactly one cycle per transfer
	assign advance = midReq && midAck;

	immPrefixTracker prefix0
	(
		.clk     (clk),
		.rstN    (rstN),
		.advance (advance),
		.instr   (midInstr.instr),
		.hasImma (hasImma),
		.imm     (imm)
	);

	decodeRs1 rs1Dec
	(
		.mode    (midInstr.mode),
		.instr   (midInstr.instr),
		.hasImma (hasImma),
		.rs1     (decoded.rs1),
		.rs1Zero (decoded.rs1Zero),
		.exc     (excRs1)
	);

	decodeRs2Rd rs2RdDec
	(
		.mode    (midInstr.mode),
		.instr   (midInstr.instr),
		.rs2     (decoded.rs2),
		.rs2Zero (decoded.rs2Zero),
		.rd      (decoded.rd),
		.exc     (excRs2Rd)
	);

	assign decoded.hasImma = hasImma;
	assign decoded.imm = imm;
	// Any operand touching a slot above the mode traps the instruction
	assign decoded.excRegPriv = excRs1 | excRs2Rd;

	handshakeStage #(.payloadT(cpuTypesPkg::decodedOperandsT)) outStage
	(
		.clk     (clk),
		.rstN    (rstN),
		.inReq   (midReq),
		.inAck   (midAck),
		.inData  (decoded),
		.outReq  (outReq),
		.outAck  (outAck),
		.outData (outData)
	);

endmodule

// ==== sim/operandDecodeTb.sv ====
// ========================================
// Testbench for the operand decode slice with
// a reference model, four-phase source and
// sink, assertion checks and a watchdog
// ========================================

`timescale 1ns/100ps

module operandDecodeTb;

	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_COUNT = 40;
	// Reset request, random mix, branches, stack pointer per mode, direct slots, MOVEMD,
	// prefix runs
	localparam int NUM_INSTR = 1 + RANDOM_COUNT + 12 + 4 + 32 + 8 + 9;

	logic                         clk;
	logic                         rstN;
	logic                         inReq;
	logic                         inAck;
	cpuTypesPkg::fetchedInstrT    inData;
	logic                         outReq;
	logic                         outAck;
	cpuTypesPkg::decodedOperandsT outData;

	integer                       seed;
	cpuTypesPkg::decodedOperandsT expQ[$];
	cpuTypesPkg::decodedOperandsT expHead;
	logic                         expValid;
	int                           sentCount;
	int                           seenCount;
	// Model of the immediate prefix that the next instruction will see
	logic                         prefixPending;
	logic [24:0]                  prefixImm;

	isaPkg::opcodeE mixOps [16] = '{isaPkg::OP_ADD, isaPkg::OP_SUB, isaPkg::OP_AND,
		isaPkg::OP_OR, isaPkg::OP_XOR, isaPkg::OP_CMP, isaPkg::OP_MUL, isaPkg::OP_DIV,
		isaPkg::OP_SHIFT, isaPkg::OP_FLT, isaPkg::OP_CSR, isaPkg::OP_MOV,
		isaPkg::OP_LOAD, isaPkg::OP_STORE, isaPkg::OP_PUSH, isaPkg::OP_POP};
	logic [2:0] brsSet [3] = '{3'd0, 3'd3, 3'd7};

	operandDecodeUnit dut0
	(
		.clk     (clk),
		.rstN    (rstN),
		.inReq   (inReq),
		.inAck   (inAck),
		.inData  (inData),
		.outReq  (outReq),
		.outAck  (outAck),
		.outData (outData)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// ========================================
	// Reference rules
	// ========================================

	// Bank mapping with the privilege exception returned in bit 7
	function automatic logic [7:0] bankMap(input logic [1:0] mode, input logic [6:0] areg);
		logic [7:0] res;
		res = {1'b0, areg};
		if (areg == 7'd31)
			res = {1'b0, 7'd120 + {5'd0, mode}};
		else if (areg >= 7'd120)
			res[7] = ((areg - 7'd120) > {5'd0, mode}) || (areg >= 7'd124);
		return res;
	endfunction

	task automatic refreshHead();
		expValid = (expQ.size() != 0);
		if (expValid)
			expHead = expQ[0];
	endtask

	// Expected bundle for one accepted instruction in acceptance order
	task automatic predict(input logic [31:0] word, input logic [1:0] mode);
		cpuTypesPkg::decodedOperandsT exp;
		logic [6:0] op;
		logic [6:0] sel1;
		logic [6:0] sel2;
		logic [6:0] selD;
		logic [1:0] mode1;
		logic [7:0] m1;
		logic [7:0] m2;
		logic [7:0] mD;
		logic       isAlu;
		op = word[6:0];
		isAlu = op inside {isaPkg::OP_ADD, isaPkg::OP_SUB, isaPkg::OP_AND, isaPkg::OP_OR,
			isaPkg::OP_XOR, isaPkg::OP_CMP, isaPkg::OP_MUL, isaPkg::OP_DIV, isaPkg::OP_SHIFT};
		sel1 = 7'd0;
		sel2 = 7'd0;
		selD = 7'd0;
		if (op == isaPkg::OP_MOV)
			sel1 = (word[28:26] < 3'd4) ? {word[20:19], word[16:12]} : {2'b00, word[16:12]};
		else if (op == isaPkg::OP_FLT)
			sel1 = 7'd32 + word[16:12];
		else if (isAlu || op inside {isaPkg::OP_CSR, isaPkg::OP_LOAD, isaPkg::OP_STORE})
			sel1 = {2'b00, word[16:12]};
		else if (op == isaPkg::OP_B)
			sel1 = (word[31] || word[24:22] == 3'd0) ? 7'd0 : 7'd64 + word[24:22];
		else if (op == isaPkg::OP_BCC)
			sel1 = (word[24:22] == 3'd0 || word[24:22] == 3'd7) ? 7'd0 : 7'd64 + word[24:22];
		// The pending immediate takes the place of source 1
		if (prefixPending)
			sel1 = 7'd0;
		if (isAlu || op == isaPkg::OP_STORE)
			sel2 = {2'b00, word[21:17]};
		else if (op == isaPkg::OP_FLT)
			sel2 = 7'd32 + word[21:17];
		if (isAlu || op inside {isaPkg::OP_CSR, isaPkg::OP_MOV, isaPkg::OP_LOAD})
			selD = {2'b00, word[11:7]};
		else if (op == isaPkg::OP_FLT)
			selD = 7'd32 + word[11:7];
		else if (op == isaPkg::OP_PUSH || op == isaPkg::OP_POP)
			selD = 7'd31;
		// MOVEMD reaches into the bank named by its mode field
		mode1 = (op == isaPkg::OP_MOV && word[28:26] == 3'd1) ? word[24:23] : mode;
		m1 = bankMap(mode1, sel1);
		m2 = bankMap(mode, sel2);
		mD = bankMap(mode, selD);
		exp.rs1 = m1[6:0];
		exp.rs2 = m2[6:0];
		exp.rd = mD[6:0];
		exp.rs1Zero = (sel1 == 7'd0);
		exp.rs2Zero = (sel2 == 7'd0);
		exp.hasImma = prefixPending;
		exp.excRegPriv = m1[7] | m2[7] | mD[7];
		exp.imm = prefixPending ? {7'd0, prefixImm} : 32'd0;
		expQ.push_back(exp);
		refreshHead();
		prefixPending = (op == isaPkg::OP_IMM);
		if (prefixPending)
			prefixImm = word[31:7];
	endtask

	// ========================================
	// Source, sink and failure reporting
	// ========================================

	task automatic sendInstr(input logic [31:0] word, input logic [1:0] mode);
		@(negedge clk);
		inData.instr = word;
		inData.mode = isaPkg::operatingModeE'(mode);
		inReq = 1'b1;
		do
			@(negedge clk);
		while (!inAck);
		predict(word, mode);
		sentCount++;
		inReq = 1'b0;
		do
			@(negedge clk);
		while (inAck);
	endtask

	task automatic reportField(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("[FAIL] time %0t: %s is %0h, expected %0h", $time, name, got, want);
		$display("Something failed");
		$fatal(1, "Output field mismatch");
	endtask

	task automatic reportEvent(input string what);
		$display("Error at time %0t: %s", $time, what);
		$display("Something failed");
		$fatal(1, "Protocol error");
	endtask

	// Sink acknowledges after a random wait and retires the queue head once released
	initial
	begin : sink
		int delay;
		@(posedge rstN);
		forever
		begin
			@(negedge clk);
			if (outReq)
			begin
				delay = $unsigned($random(seed)) % 6;
				repeat (delay)
					@(negedge clk);
				outAck = 1'b1;
				do
					@(negedge clk);
				while (outReq);
				outAck = 1'b0;
				if (expQ.size() != 0)
					void'(expQ.pop_front());
				seenCount++;
				refreshHead();
			end
		end
	end

	// Each field is compared with the queue head in the cycle outReq comes up
	checkRs1: assert property (@(posedge clk) disable iff (!rstN)
		$rose(outReq) |-> outData.rs1 == expHead.rs1)
		else reportField("rs1", outData.rs1, expHead.rs1);
	checkRs2: assert property (@(posedge clk) disable iff (!rstN)
		$rose(outReq) |-> outData.rs2 == expHead.rs2)
		else reportField("rs2", outData.rs2, expHead.rs2);
	checkRd: assert property (@(posedge clk) disable iff (!rstN)
		$rose(outReq) |-> outData.rd == expHead.rd)
		else reportField("rd", outData.rd, expHead.rd);
	checkRs1Zero: assert property (@(posedge clk) disable iff (!rstN)
		$rose(outReq) |-> outData.rs1Zero == expHead.rs1Zero)
		else reportField("rs1Zero", outData.rs1Zero, expHead.rs1Zero);
	checkRs2Zero: assert property (@(posedge clk) disable iff (!rstN)
		$rose(outReq) |-> outData.rs2Zero == expHead.rs2Zero)
		else reportField("rs2Zero", outData.rs2Zero, expHead.rs2Zero);
	checkHasImma: assert property (@(posedge clk) disable iff (!rstN)
		$rose(outReq) |-> outData.hasImma == expHead.hasImma)
		else reportField("hasImma", outData.hasImma, expHead.hasImma);
	checkExc: assert property (@(posedge clk) disable iff (!rstN)
		$rose(outReq) |-> outData.excRegPriv == expHead.excRegPriv)
		else reportField("excRegPriv", outData.excRegPriv, expHead.excRegPriv);
	checkImm: assert property (@(posedge clk) disable iff (!rstN)
		$rose(outReq) |-> outData.imm == expHead.imm)
		else reportField("imm", outData.imm, expHead.imm);
	checkExpected: assert property (@(posedge clk) disable iff (!rstN)
		$rose(outReq) |-> expValid)
		else reportEvent("an output appeared with no instruction waiting for it");
	checkResetQuiet: assert property (@(posedge clk) !rstN |-> !outReq && !inAck)
		else reportEvent("outReq or inAck went high during reset");

	initial
	begin
		repeat (RESET_CYCLES + NUM_INSTR * 20)
			@(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles",
			RESET_CYCLES + NUM_INSTR * 20);
		$display("Something failed");
		$fatal(1, "Watchdog expired");
	end

	// ========================================
	// Stimulus
	// ========================================

	initial
	begin
		logic [31:0] word;
		int          i;
		int          m;
		int          s;
		int          k;
		int          top;
		seed = 32'h7872_014e;
		rstN = 1'b0;
		inReq = 1'b0;
		outAck = 1'b0;
		inData = '0;
		sentCount = 0;
		seenCount = 0;
		prefixPending = 1'b0;
		prefixImm = '0;
		expValid = 1'b0;
		expHead = '0;
		repeat (RESET_CYCLES - 4)
			@(posedge clk);

		// A request raised while reset is still held has to wait for its release
		fork
			sendInstr({10'd0, 5'd2, 5'd1, 5'd3, isaPkg::OP_ADD}, 2'd3);
			begin
				repeat (4)
					@(posedge clk);
				@(negedge clk);
				rstN = 1'b1;
			end
		join

		// Random operand mix in machine mode
		for (i = 0; i < RANDOM_COUNT; i++)
		begin
			word = $random(seed);
			word[6:0] = mixOps[$unsigned($random(seed)) % 16];
			sendInstr(word, 2'd3);
		end

		// Branch register select for both branch kinds
		for (i = 0; i < 2; i++)
			for (k = 0; k < 3; k++)
				for (top = 0; top < 2; top++)
				begin
					word = $random(seed);
					word[6:0] = (i == 1) ? isaPkg::OP_BCC : isaPkg::OP_B;
					word[24:22] = brsSet[k];
					word[31] = top[0];
					sendInstr(word, 2'd3);
				end

		// Stack pointer in all three operand positions per mode
		for (m = 0; m < 4; m++)
			sendInstr({10'd0, 5'd31, 5'd31, 5'd31, isaPkg::OP_ADD}, m[1:0]);

		// Every banked slot named directly from every mode
		for (m = 0; m < 4; m++)
			for (s = 0; s < 8; s++)
			begin
				word = $random(seed);
				word[6:0] = isaPkg::OP_MOV;
				word[28:26] = 3'd0;
				word[20:19] = 2'b11;
				word[16:12] = 5'(24 + s);
				sendInstr(word, m[1:0]);
			end

		// MOVEMD from user mode into each target bank
		for (m = 0; m < 4; m++)
			for (k = 0; k < 2; k++)
			begin
				word = $random(seed);
				word[6:0] = isaPkg::OP_MOV;
				word[28:26] = 3'd1;
				word[24:23] = m[1:0];
				word[20:19] = (k == 0) ? 2'b00 : 2'b11;
				word[16:12] = (k == 0) ? 5'd31 : 5'd27;
				sendInstr(word, 2'd0);
			end

		// Prefix, the instruction it feeds, then one without it
		for (i = 0; i < 3; i++)
		begin
			word = $random(seed);
			word[6:0] = isaPkg::OP_IMM;
			sendInstr(word, 2'd3);
			for (k = 0; k < 2; k++)
			begin
				word = $random(seed);
				word[6:0] = isaPkg::OP_ADD;
				sendInstr(word, 2'd3);
			end
		end

		while (expQ.size() != 0)
			@(negedge clk);
		repeat (10)
			@(negedge clk);
		if (seenCount != sentCount || sentCount != NUM_INSTR || outReq)
		begin
			$display("Error: %0d instructions sent, %0d results seen", sentCount, seenCount);
			$display("Something failed");
			$fatal(1, "Result count mismatch");
		end
		else
		begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

// ==== sim.f ====
hw/isaPkg.sv
hw/cpuTypesPkg.sv
hw/regMapper.sv
hw/decodeRs1.sv
hw/decodeRs2Rd.sv
hw/immPrefixTracker.sv
hw/handshakeStage.sv
hw/operandDecodeUnit.sv
sim/operandDecodeTb.sv

// ==== Bender.yml ====
package:
  name: operand_decode

sources:
  - hw/isaPkg.sv
  - hw/cpuTypesPkg.sv
  - hw/regMapper.sv
  - hw/decodeRs1.sv
  - hw/decodeRs2Rd.sv
  - hw/immPrefixTracker.sv
  - hw/handshakeStage.sv
  - hw/operandDecodeUnit.sv
  - target: simulation
    files:
      - sim/operandDecodeTb.sv
